/* hw/ls_isa_pkg.sv */
`default_nettype none

package ls_isa_pkg;

    // Load/store funct3 field
    typedef enum logic [2:0] {
        LS_B = 3'd0,
        LS_H = 3'd1,
        LS_W = 3'd2,
        L_BU = 3'd4,
        L_HU = 3'd5
    } ls_fn3_t;

    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_FENCE = 2'd2
    } ls_op_t;

    // mcause values for the two alignment traps
    typedef enum logic [4:0] {
        LOAD_ADDR_MISALIGNED      = 5'd4,
        STORE_AMO_ADDR_MISALIGNED = 5'd6
    } ls_exc_code_t;

endpackage

`default_nettype wire

/* hw/lsu_config_pkg.sv */
`default_nettype none

package lsu_config_pkg;

    ////////////////////
    // Address map
    localparam logic [31:0] LOCAL_MEM_BASE = 32'h0000_0000;
    localparam int LOCAL_MEM_WORDS = 256;
    localparam int LOCAL_ADDR_W = $clog2(LOCAL_MEM_WORDS) + 2;

    localparam logic [31:0] PBUS_BASE = 32'h8000_0000;
    localparam int PBUS_REGS = 16;
    localparam int PBUS_ADDR_W = $clog2(PBUS_REGS) + 2;

    ////////////////////
    // Sub-units and load tracking
    localparam int ID_W = 4;
    localparam int NUM_SUB_UNITS = 2;
    localparam int SUB_UNIT_W = $clog2(NUM_SUB_UNITS);
    localparam int LOCAL_UNIT = 0;
    localparam int PBUS_UNIT = 1;

    localparam int LOCAL_RD_LATENCY = 1;
    localparam int PBUS_RD_LATENCY = 2;
    // One slot per cycle of the slowest unit
    localparam int ATTR_DEPTH = (PBUS_RD_LATENCY > LOCAL_RD_LATENCY) ?
                                PBUS_RD_LATENCY : LOCAL_RD_LATENCY;

    // {id, fn3, byte offset, subunit index}
    localparam int ATTR_W = ID_W + 3 + 2 + SUB_UNIT_W;

endpackage

`default_nettype wire

/* hw/ls_address_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_address_stage
    import ls_isa_pkg::*;
    import lsu_config_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                new_request,
    input  wire ls_op_t        op,
    input  wire ls_fn3_t       fn3,
    input  wire [31:0]         rs1,
    input  wire [11:0]         offset,
    input  wire [31:0]         rs2,
    input  wire [ID_W-1:0]     id,
    input  wire                req_accept,
    input  wire                exc_ack,
    input  wire                load_store_idle,
    output logic               issue_ready,
    output logic               req_valid,
    output logic [31:0]        req_addr,
    output ls_op_t             req_op,
    output ls_fn3_t            req_fn3,
    output logic [3:0]         req_be,
    output logic [31:0]        req_data,
    output logic [ID_W-1:0]    req_id,
    output logic               exc_valid,
    output ls_exc_code_t       exc_code,
    output logic [31:0]        exc_tval,
    output logic [ID_W-1:0]    exc_id,
    output logic               exc_load_done
);

    logic [31:0] eff_addr;
    logic        misaligned;
    logic [3:0]  be;
    logic        issue;
    logic        load_req;
    logic        new_exception;
    logic        fence_hold;

    assign eff_addr = rs1 + {{20{offset[11]}}, offset};

    always_comb begin
        case (fn3)
            LS_H, L_HU: misaligned = eff_addr[0];
            LS_W:       misaligned = |eff_addr[1:0];
            default:    misaligned = 1'b0;
        endcase
    end

    // Byte lanes follow the low address bits
    always_comb begin
        case (fn3[1:0])
            2'b00:   be = 4'b0001 << eff_addr[1:0];
            2'b01:   be = 4'b0011 << {eff_addr[1], 1'b0};
            default: be = 4'b1111;
        endcase
    end

    ////////////////////
    // Issue and request register
    assign issue_ready = ~fence_hold & ~exc_valid & (~req_valid | req_accept);
    assign issue = new_request & issue_ready;
    assign load_req = issue & (op != OP_FENCE) & ~misaligned;
    assign new_exception = issue & (op != OP_FENCE) & misaligned;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (load_req) begin
            req_valid <= 1'b1;
        end else if (req_accept) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_req) begin
            req_addr <= eff_addr;
            req_op   <= op;
            req_fn3  <= fn3;
            req_be   <= be;
            req_data <= rs2 << {eff_addr[1:0], 3'b000};
            req_id   <= id;
        end
    end

    ////////////////////
    // Exception record and fence
    always_ff @(posedge clk) begin
        if (rst) begin
            exc_valid     <= 1'b0;
            exc_load_done <= 1'b0;
            fence_hold    <= 1'b0;
        end else begin
            exc_valid     <= (exc_valid & ~exc_ack) | new_exception;
            exc_load_done <= exc_valid & exc_ack & (exc_code == LOAD_ADDR_MISALIGNED);
            fence_hold    <= (fence_hold & ~load_store_idle) | (issue & (op == OP_FENCE));
        end
    end

    always_ff @(posedge clk) begin
        if (new_exception) begin
            exc_code <= (op == OP_STORE) ? STORE_AMO_ADDR_MISALIGNED : LOAD_ADDR_MISALIGNED;
            exc_tval <= eff_addr;
            exc_id   <= id;
        end
    end

endmodule

`default_nettype wire

/* hw/ls_request_router.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_request_router
    import ls_isa_pkg::*;
    import lsu_config_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    input  wire [31:0]               req_addr,
    input  wire ls_op_t              req_op,
    input  wire ls_fn3_t             req_fn3,
    input  wire [ID_W-1:0]           req_id,
    input  wire [NUM_SUB_UNITS-1:0]  unit_ready,
    input  wire                      attr_full,
    input  wire                      attr_valid,
    output logic                     req_accept,
    output logic [NUM_SUB_UNITS-1:0] unit_new_request,
    output logic                     attr_push,
    output logic [ATTR_W-1:0]        attr_data
);

    logic                  local_hit;
    logic                  pbus_hit;
    logic [SUB_UNIT_W-1:0] target_unit;
    logic [SUB_UNIT_W-1:0] last_unit;
    logic                  switch_stall;

    ////////////////////
    // Range decode
    assign local_hit = req_addr[31:LOCAL_ADDR_W] == LOCAL_MEM_BASE[31:LOCAL_ADDR_W];
    assign pbus_hit  = req_addr[31:PBUS_ADDR_W] == PBUS_BASE[31:PBUS_ADDR_W];

    // Unmapped addresses alias into the local RAM
    assign target_unit = (pbus_hit && !local_hit) ? SUB_UNIT_W'(PBUS_UNIT)
                                                  : SUB_UNIT_W'(LOCAL_UNIT);

    // Results must come back in order, so no switch with loads in flight
    assign switch_stall = (target_unit != last_unit) && attr_valid;

    assign req_accept = req_valid && unit_ready[target_unit] && !attr_full && !switch_stall;

    always_comb begin
        for (int i = 0; i < NUM_SUB_UNITS; i++) begin
            unit_new_request[i] = req_accept && (target_unit == SUB_UNIT_W'(i));
        end
    end

    ////////////////////
    // Load attributes
    assign attr_push = req_accept && (req_op == OP_LOAD);
    assign attr_data = {req_id, req_fn3, req_addr[1:0], target_unit};

    always_ff @(posedge clk) begin
        if (rst) begin
            last_unit <= SUB_UNIT_W'(LOCAL_UNIT);
        end else if (attr_push) begin
            last_unit <= target_unit;
        end
    end

endmodule

`default_nettype wire

/* hw/load_attr_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module load_attr_fifo
    import lsu_config_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               push,
    input  wire [ATTR_W-1:0]  data_in,
    input  wire               pop,
    output logic [ATTR_W-1:0] data_out,
    output logic              valid,
    output logic              full
);

    localparam int PTR_W = (ATTR_DEPTH > 1) ? $clog2(ATTR_DEPTH) : 1;
    localparam int CNT_W = $clog2(ATTR_DEPTH + 1);

    logic [ATTR_W-1:0] entries [ATTR_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign valid = count != '0;
    assign full = count == CNT_W'(ATTR_DEPTH);
    assign do_push = push & ~full;
    assign do_pop = pop & valid;

    // Show-ahead head entry
    assign data_out = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(ATTR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(ATTR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= data_in;
        end
    end

endmodule

`default_nettype wire

/* hw/local_mem_sub_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module local_mem_sub_unit
    import lsu_config_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         new_request,
    input  wire  [31:0] addr,
    input  wire         we,
    input  wire  [3:0]  be,
    input  wire  [31:0] wdata,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] rdata
);

    logic [31:0] mem [LOCAL_MEM_WORDS];
    logic [LOCAL_ADDR_W-3:0] word_idx;

    assign word_idx = addr[LOCAL_ADDR_W-1:2];

    // Accepts every cycle once out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            ready      <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            ready      <= 1'b1;
            data_valid <= new_request & ~we;
        end
    end

    ////////////////////
    // Data array
    always_ff @(posedge clk) begin
        if (new_request && we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_request && !we) begin
            rdata <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

/* hw/pbus_sub_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pbus_sub_unit
    import lsu_config_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         new_request,
    input  wire  [31:0] addr,
    input  wire         we,
    input  wire  [3:0]  be,
    input  wire  [31:0] wdata,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] rdata
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        RESP
    } pbus_state_t;

    pbus_state_t state;
    logic [31:0] regs [PBUS_REGS];
    logic [PBUS_ADDR_W-3:0] reg_idx;
    logic [PBUS_ADDR_W-3:0] rd_idx;

    assign reg_idx = addr[PBUS_ADDR_W-1:2];
    assign ready = state == IDLE;
    assign data_valid = state == RESP;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            for (int r = 0; r < PBUS_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (new_request && we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (be[b]) begin
                                regs[reg_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                            end
                        end
                    end else if (new_request) begin
                        state <= WAIT;
                    end
                end
                WAIT:    state <= RESP;
                default: state <= IDLE;
            endcase
        end
    end

    // Read index and response word
    always_ff @(posedge clk) begin
        if (state == IDLE && new_request) begin
            rd_idx <= reg_idx;
        end
        if (state == WAIT) begin
            rdata <= regs[rd_idx];
        end
    end

endmodule

`default_nettype wire

/* hw/load_align_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align_stage
    import ls_isa_pkg::*;
    import lsu_config_pkg::*;
(
    input  wire [ATTR_W-1:0]        attr_data,
    input  wire                     attr_valid,
    input  wire [NUM_SUB_UNITS-1:0] unit_data_valid,
    input  wire [31:0]              unit_rdata [NUM_SUB_UNITS],
    input  wire                     exc_load_done,
    input  wire [ID_W-1:0]          exc_id,
    output logic                    attr_pop,
    output logic                    wb_done,
    output logic [ID_W-1:0]         wb_id,
    output logic [31:0]             wb_data
);

    logic [ID_W-1:0]       attr_id;
    ls_fn3_t               attr_fn3;
    logic [1:0]            attr_byte;
    logic [SUB_UNIT_W-1:0] attr_unit;
    logic [31:0]           unit_word;
    logic [31:0]           shifted;

    assign attr_id   = attr_data[ATTR_W-1 -: ID_W];
    assign attr_fn3  = ls_fn3_t'(attr_data[SUB_UNIT_W+2 +: 3]);
    assign attr_byte = attr_data[SUB_UNIT_W +: 2];
    assign attr_unit = attr_data[SUB_UNIT_W-1:0];

    ////////////////////
    // Select and align
    assign unit_word = unit_rdata[attr_unit];
    assign shifted = unit_word >> {attr_byte, 3'b000};

    always_comb begin
        case (attr_fn3)
            LS_B:    wb_data = {{24{shifted[7]}}, shifted[7:0]};
            L_BU:    wb_data = {24'd0, shifted[7:0]};
            LS_H:    wb_data = {{16{shifted[15]}}, shifted[15:0]};
            L_HU:    wb_data = {16'd0, shifted[15:0]};
            default: wb_data = unit_word;
        endcase
    end

    ////////////////////
    // Writeback
    assign attr_pop = attr_valid & |unit_data_valid;
    // A trapped load completes with its ID only
    assign wb_done = attr_pop | exc_load_done;
    assign wb_id = exc_load_done ? exc_id : attr_id;

endmodule

`default_nettype wire

/* hw/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
    import ls_isa_pkg::*;
    import lsu_config_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              new_request,
    input  wire ls_op_t      op,
    input  wire ls_fn3_t     fn3,
    input  wire [31:0]       rs1,
    input  wire [11:0]       offset,
    input  wire [31:0]       rs2,
    input  wire [ID_W-1:0]   id,
    output logic             issue_ready,
    output logic             exc_valid,
    output ls_exc_code_t     exc_code,
    output logic [31:0]      exc_tval,
    output logic [ID_W-1:0]  exc_id,
    input  wire              exc_ack,
    output logic             wb_done,
    output logic [ID_W-1:0]  wb_id,
    output logic [31:0]      wb_data,
    output logic             load_store_idle
);

    logic                     req_valid;
    logic [31:0]              req_addr;
    ls_op_t                   req_op;
    ls_fn3_t                  req_fn3;
    logic [3:0]               req_be;
    logic [31:0]              req_data;
    logic [ID_W-1:0]          req_id;
    logic                     req_accept;
    logic                     exc_load_done;

    logic [NUM_SUB_UNITS-1:0] unit_new_request;
    logic [NUM_SUB_UNITS-1:0] unit_ready;
    logic [NUM_SUB_UNITS-1:0] unit_data_valid;
    logic [31:0]              unit_rdata [NUM_SUB_UNITS];

    logic                     attr_push;
    logic                     attr_pop;
    logic [ATTR_W-1:0]        attr_data_in;
    logic [ATTR_W-1:0]        attr_data_out;
    logic                     attr_valid;
    logic                     attr_full;

    assign load_store_idle = ~req_valid & ~attr_valid & (&unit_ready);

    ls_address_stage addr_stage (
        .clk(clk), .rst(rst),
        .new_request(new_request), .op(op), .fn3(fn3), .rs1(rs1),
        .offset(offset), .rs2(rs2), .id(id),
        .req_accept(req_accept), .exc_ack(exc_ack), .load_store_idle(load_store_idle),
        .issue_ready(issue_ready), .req_valid(req_valid), .req_addr(req_addr),
        .req_op(req_op), .req_fn3(req_fn3), .req_be(req_be), .req_data(req_data),
        .req_id(req_id), .exc_valid(exc_valid), .exc_code(exc_code),
        .exc_tval(exc_tval), .exc_id(exc_id), .exc_load_done(exc_load_done)
    );

    ls_request_router router (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_addr(req_addr), .req_op(req_op),
        .req_fn3(req_fn3), .req_id(req_id), .unit_ready(unit_ready),
        .attr_full(attr_full), .attr_valid(attr_valid),
        .req_accept(req_accept), .unit_new_request(unit_new_request),
        .attr_push(attr_push), .attr_data(attr_data_in)
    );

    load_attr_fifo attr_fifo (
        .clk(clk), .rst(rst),
        .push(attr_push), .data_in(attr_data_in), .pop(attr_pop),
        .data_out(attr_data_out), .valid(attr_valid), .full(attr_full)
    );

    ////////////////////
    // Sub-units share the request payload
    local_mem_sub_unit local_mem (
        .clk(clk), .rst(rst),
        .new_request(unit_new_request[LOCAL_UNIT]), .addr(req_addr),
        .we(req_op == OP_STORE), .be(req_be), .wdata(req_data),
        .ready(unit_ready[LOCAL_UNIT]), .data_valid(unit_data_valid[LOCAL_UNIT]),
        .rdata(unit_rdata[LOCAL_UNIT])
    );

    pbus_sub_unit pbus (
        .clk(clk), .rst(rst),
        .new_request(unit_new_request[PBUS_UNIT]), .addr(req_addr),
        .we(req_op == OP_STORE), .be(req_be), .wdata(req_data),
        .ready(unit_ready[PBUS_UNIT]), .data_valid(unit_data_valid[PBUS_UNIT]),
        .rdata(unit_rdata[PBUS_UNIT])
    );

    load_align_stage align (
        .attr_data(attr_data_out), .attr_valid(attr_valid),
        .unit_data_valid(unit_data_valid), .unit_rdata(unit_rdata),
        .exc_load_done(exc_load_done), .exc_id(exc_id),
        .attr_pop(attr_pop), .wb_done(wb_done), .wb_id(wb_id), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

/* verif/lsu_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import ls_isa_pkg::*;
    import lsu_config_pkg::*;
();

    localparam int VEC_FIELDS = 8;
    localparam int MAX_VECTORS = 64;
    localparam int READY_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 50;
    localparam string VEC_FILE = "verif/lsu_input.txt";

    logic              clk;
    logic              rst;
    logic              new_request;
    ls_op_t            op;
    ls_fn3_t           fn3;
    logic [31:0]       rs1;
    logic [11:0]       offset;
    logic [31:0]       rs2;
    logic [ID_W-1:0]   id;
    logic              exc_ack;
    logic              issue_ready;
    logic              exc_valid;
    ls_exc_code_t      exc_code;
    logic [31:0]       exc_tval;
    logic [ID_W-1:0]   exc_id;
    logic              wb_done;
    logic [ID_W-1:0]   wb_id;
    logic [31:0]       wb_data;
    logic              load_store_idle;

    logic [31:0]       vec_mem [VEC_FIELDS*MAX_VECTORS];
    int                num_vectors;
    bit                vectors_loaded = 1'b0;
    int                errors;
    integer            seed;

    // Expected writebacks and exceptions, oldest first
    logic [ID_W-1:0]   exp_wb_id [$];
    logic [31:0]       exp_wb_data [$];
    bit                exp_wb_has_data [$];
    ls_exc_code_t      exp_exc_code [$];
    logic [31:0]       exp_exc_tval [$];
    logic [ID_W-1:0]   exp_exc_id [$];

    lsu_clock_gen clock_gen (
        .clk(clk),
        .rst(rst)
    );

    load_store_unit dut0 (
        .clk(clk), .rst(rst),
        .new_request(new_request), .op(op), .fn3(fn3), .rs1(rs1),
        .offset(offset), .rs2(rs2), .id(id),
        .issue_ready(issue_ready),
        .exc_valid(exc_valid), .exc_code(exc_code), .exc_tval(exc_tval),
        .exc_id(exc_id), .exc_ack(exc_ack),
        .wb_done(wb_done), .wb_id(wb_id), .wb_data(wb_data),
        .load_store_idle(load_store_idle)
    );

    ////////////////////
    // Driver helpers
    task automatic wait_issue_ready();
        int waited;
        waited = 0;
        while (!issue_ready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (issue_ready) else begin
            errors++;
            $display("issue_ready stayed low for %0d cycles at %0t", waited, $time);
        end
    endtask

    // Loads issued before the fence must all be back when it lets go
    task automatic check_fence_release();
        assert (!issue_ready) else begin
            errors++;
            $display("issue_ready was still high in the cycle after a fence at %0t", $time);
        end
        wait_issue_ready();
        assert (exp_wb_id.size() == 0) else begin
            errors++;
            $display("Fence released issue with %0d loads outstanding at %0t",
                     exp_wb_id.size(), $time);
        end
    endtask

    task automatic issue_vector(input int n);
        int          base;
        logic [31:0] addr;
        logic [31:0] want_exc;
        base = n * VEC_FIELDS;
        wait_issue_ready();
        new_request = 1'b1;
        op = ls_op_t'(vec_mem[base][1:0]);
        fn3 = ls_fn3_t'(vec_mem[base+1][2:0]);
        rs1 = vec_mem[base+2];
        offset = vec_mem[base+3][11:0];
        rs2 = vec_mem[base+4];
        id = vec_mem[base+5][ID_W-1:0];
        want_exc = vec_mem[base+6];
        addr = rs1 + {{20{offset[11]}}, offset};
        if (want_exc != 0) begin
            exp_exc_code.push_back(ls_exc_code_t'(want_exc[4:0]));
            exp_exc_tval.push_back(addr);
            exp_exc_id.push_back(id);
        end
        // A trapped load still completes, but with its ID only
        if (op == OP_LOAD) begin
            exp_wb_id.push_back(id);
            exp_wb_data.push_back(vec_mem[base+7]);
            exp_wb_has_data.push_back(want_exc == 0);
        end
        @(negedge clk);
        new_request = 1'b0;
        if (op == OP_FENCE) begin
            check_fence_release();
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_wb_id.size() != 0 || exp_exc_id.size() != 0) && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_wb_id.size() == 0 && exp_exc_id.size() == 0) else begin
            errors++;
            $display("%0d writebacks and %0d exceptions never arrived",
                     exp_wb_id.size(), exp_exc_id.size());
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!load_store_idle && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (load_store_idle) else begin
            errors++;
            $display("Unit was not idle after the last operation");
        end
    endtask

    task automatic print_summary();
        $display("Errors: %0d, vectors run: %0d", errors, num_vectors);
    endtask

    ////////////////////
    // Response checks
    task automatic check_writeback();
        logic [ID_W-1:0] want_id;
        logic [31:0]     want_data;
        bit              has_data;
        assert (exp_wb_id.size() != 0) else begin
            errors++;
            $display("Writeback with ID %h arrived with no load outstanding at %0t",
                     wb_id, $time);
        end
        if (exp_wb_id.size() == 0) begin
            return;
        end
        want_id = exp_wb_id.pop_front();
        want_data = exp_wb_data.pop_front();
        has_data = exp_wb_has_data.pop_front();
        assert (wb_id == want_id) else begin
            errors++;
            $display("** Error: wb_id = %h, expected %h at %0t", wb_id, want_id, $time);
        end
        if (has_data) begin
            assert (wb_data == want_data) else begin
                errors++;
                $display("** Error: wb_data = %h, expected %h (id %h) at %0t",
                         wb_data, want_data, want_id, $time);
            end
        end
    endtask

    task automatic check_exception();
        ls_exc_code_t    want_code;
        logic [31:0]     want_tval;
        logic [ID_W-1:0] want_id;
        assert (exp_exc_code.size() != 0) else begin
            errors++;
            $display("Exception with code %h raised where none was expected at %0t",
                     exc_code, $time);
        end
        if (exp_exc_code.size() == 0) begin
            return;
        end
        want_code = exp_exc_code.pop_front();
        want_tval = exp_exc_tval.pop_front();
        want_id = exp_exc_id.pop_front();
        assert (exc_code == want_code) else begin
            errors++;
            $display("** Error: exc_code = %h, expected %h at %0t", exc_code, want_code, $time);
        end
        assert (exc_tval == want_tval) else begin
            errors++;
            $display("** Error: exc_tval = %h, expected %h at %0t", exc_tval, want_tval, $time);
        end
        assert (exc_id == want_id) else begin
            errors++;
            $display("** Error: exc_id = %h, expected %h at %0t", exc_id, want_id, $time);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && wb_done) begin
            check_writeback();
        end
    end

    // Ack one cycle after the exception shows up
    always @(posedge clk) begin
        if (!rst && exc_valid) begin
            check_exception();
            @(negedge clk);
            exc_ack = 1'b1;
            @(negedge clk);
            exc_ack = 1'b0;
        end
    end

    ////////////////////
    // Main sequence
    initial begin
        int n;
        int gap;
        seed = 32'h6683_bfe6;
        errors = 0;
        num_vectors = 0;
        new_request = 1'b0;
        op = OP_LOAD;
        fn3 = LS_W;
        rs1 = '0;
        offset = '0;
        rs2 = '0;
        id = '0;
        exc_ack = 1'b0;
        $readmemh(VEC_FILE, vec_mem);
        while (num_vectors < MAX_VECTORS && !$isunknown(vec_mem[num_vectors*VEC_FIELDS])) begin
            num_vectors++;
        end
        vectors_loaded = 1'b1;
        assert (num_vectors > 0) else begin
            errors++;
            $display("No vectors could be read from %s", VEC_FILE);
        end
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        for (n = 0; n < num_vectors; n++) begin
            gap = $unsigned($random(seed)) % 4;
            // A fence right behind its loads still has them in flight
            if (vec_mem[n*VEC_FIELDS][1:0] == OP_FENCE) begin
                gap = 0;
            end
            repeat (gap) @(negedge clk);
            issue_vector(n);
        end
        wait_drain();
        wait_idle();
        print_summary();
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Budget of 20 cycles per vector plus margin for reset and drain
    initial begin
        wait (vectors_loaded);
        repeat (num_vectors * 20 + 100) @(posedge clk);
        errors++;
        $display("Watchdog timeout after %0d cycles, run did not complete",
                 num_vectors * 20 + 100);
        print_summary();
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hw/ls_isa_pkg.sv
hw/lsu_config_pkg.sv
hw/ls_address_stage.sv
hw/ls_request_router.sv
hw/load_attr_fifo.sv
hw/local_mem_sub_unit.sv
hw/pbus_sub_unit.sv
hw/load_align_stage.sv
hw/load_store_unit.sv
verif/lsu_clock_gen.sv
verif/lsu_tb.sv

/* verif/lsu_input.txt */
// op fn3 rs1 offset rs2 id exc wb_data (all hex)
// op 0 load 1 store 2 fence, exc is the expected exception code or 0
1 2 00000100 000 11223344 1 0 00000000
1 2 00000100 004 a5b6c7d8 2 0 00000000
0 2 00000100 000 00000000 3 0 11223344
0 2 00000100 004 00000000 4 0 a5b6c7d8
1 0 00000200 000 00000081 5 0 00000000
1 0 00000200 001 000000f2 6 0 00000000
1 0 00000200 002 00000063 7 0 00000000
1 0 00000200 003 000000c4 8 0 00000000
1 1 00000204 000 00008a7b 9 0 00000000
1 1 00000204 002 00001e9f a 0 00000000
0 2 00000200 000 00000000 b 0 c463f281
0 0 00000200 000 00000000 c 0 ffffff81
0 4 00000200 001 00000000 d 0 000000f2
0 0 00000200 002 00000000 e 0 00000063
0 0 00000200 003 00000000 f 0 ffffffc4
0 1 00000204 000 00000000 0 0 ffff8a7b
0 5 00000204 002 00000000 1 0 00001e9f
0 5 00000200 002 00000000 2 0 0000c463
0 1 00000200 002 00000000 3 0 ffffc463
1 2 80000000 000 deadbeef 4 0 00000000
1 1 80000000 006 0000cafe 5 0 00000000
0 2 80000000 000 00000000 6 0 deadbeef
0 2 00000100 000 00000000 7 0 11223344
0 5 80000004 002 00000000 8 0 0000cafe
0 0 00000200 000 00000000 9 0 ffffff81
0 1 80000000 002 00000000 a 0 ffffdead
0 2 80000000 03c 00000000 b 0 00000000
2 0 00000000 000 00000000 c 0 00000000
0 2 00000100 002 00000000 d 4 00000000
0 1 00000200 001 00000000 e 4 00000000
1 2 00000100 001 ffffffff f 6 00000000
0 2 00000100 000 00000000 0 0 11223344
0 2 00000108 ffc 00000000 1 0 a5b6c7d8
1 0 00000210 ff0 0000007e 2 0 00000000
0 4 00000204 ffc 00000000 3 0 0000007e
2 0 00000000 000 00000000 4 0 00000000
0 2 80000040 fc0 00000000 5 0 deadbeef
